//--- filelist.f
logic/acq_pkg.sv
logic/sample_gatherer.sv
logic/acq_record_mux.sv
logic/acq_sequencer.sv
logic/acq_formatter_top.sv
verification/acq_formatter_sva.sv
verification/acq_formatter_tb.sv

//--- logic/acq_formatter_top.sv
`default_nettype none

module acq_formatter_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             trigger,
    input  logic [acq_pkg::pair_w-1:0]       adc_pair,
    input  logic                             adc_valid,
    input  logic [acq_pkg::fill_num_w-1:0]   fill_num,
    input  logic [acq_pkg::fill_type_w-1:0]  fill_type,
    input  logic [acq_pkg::bursts_w-1:0]     num_fill_bursts,
    input  logic [acq_pkg::adr_w-1:0]        burst_start_adr,
    input  logic [acq_pkg::wave_cnt_w-1:0]   num_waveforms,
    input  logic [acq_pkg::gap_w-1:0]        waveform_gap,
    input  logic [acq_pkg::chan_tag_w-1:0]   channel_tag,
    input  logic [acq_pkg::alarm_w-1:0]      xadc_alarms,
    output logic [acq_pkg::rec_w-1:0]        rec_dat,     // to the ddr3 write fifo
    output logic                             rec_valid,
    output logic                             fill_busy,
    output logic                             fill_done
);
    import acq_pkg::*;

    logic                   capture_en;
    logic [burst_w-1:0]     burst_dat;
    logic                   burst_valid;
    logic                   select_fill_hdr;
    logic                   select_wave_hdr;
    logic                   select_dat;
    logic                   select_checksum;
    logic [wave_cnt_w-1:0]  cur_wave_num;

    // adc words -> 4-word bursts
    sample_gatherer u_gatherer (
        .clk         (clk),
        .rst_n       (rst_n),
        .capture_en  (capture_en),
        .adc_pair    (adc_pair),
        .adc_valid   (adc_valid),
        .burst_dat   (burst_dat),
        .burst_valid (burst_valid)
    );

    // record order and timing
    acq_sequencer u_sequencer (
        .clk             (clk),
        .rst_n           (rst_n),
        .trigger         (trigger),
        .num_fill_bursts (num_fill_bursts),
        .num_waveforms   (num_waveforms),
        .waveform_gap    (waveform_gap),
        .burst_valid     (burst_valid),
        .capture_en      (capture_en),
        .select_fill_hdr (select_fill_hdr),
        .select_wave_hdr (select_wave_hdr),
        .select_dat      (select_dat),
        .select_checksum (select_checksum),
        .cur_wave_num    (cur_wave_num),
        .fill_busy       (fill_busy),
        .fill_done       (fill_done)
    );

    // record packing, checksum, output register
    acq_record_mux u_record_mux (
        .clk             (clk),
        .rst_n           (rst_n),
        .fill_num        (fill_num),
        .fill_type       (fill_type),
        .num_fill_bursts (num_fill_bursts),
        .burst_start_adr (burst_start_adr),
        .num_waveforms   (num_waveforms),
        .waveform_gap    (waveform_gap),
        .channel_tag     (channel_tag),
        .xadc_alarms     (xadc_alarms),
        .cur_wave_num    (cur_wave_num),
        .burst_dat       (burst_dat),
        .select_fill_hdr (select_fill_hdr),
        .select_wave_hdr (select_wave_hdr),
        .select_dat      (select_dat),
        .select_checksum (select_checksum),
        .rec_dat         (rec_dat),
        .rec_valid       (rec_valid)
    );

endmodule

`default_nettype wire

//--- logic/acq_pkg.sv
`default_nettype none

package acq_pkg;

    //////////////////////////////
    // record framing
    //////////////////////////////

    localparam int tag_w      = 4;                  // record tag, top nibble
    localparam int body_w     = 128;                // header, data or checksum body
    localparam int rec_w      = tag_w + body_w;     // 132 bits into the write fifo
    localparam int marker_w   = 2;

    // record tags
    localparam logic [tag_w-1:0] tag_fill_hdr = 4'd1;
    localparam logic [tag_w-1:0] tag_wave_hdr = 4'd2;
    localparam logic [tag_w-1:0] tag_data     = 4'd3;
    localparam logic [tag_w-1:0] tag_checksum = 4'd4;

    // body[127:126] of both headers
    // sign-extended data only ever shows 00 or 11 there
    localparam logic [marker_w-1:0] hdr_marker = 2'b01;

    //////////////////////////////
    // adc words
    //////////////////////////////

    localparam int pair_w          = 26;            // two 13-bit samples per word
    localparam int smp_w           = 12;            // sample bits, over-range bit below
    localparam int lane_w          = 16;            // one sign-extended sample in a record
    localparam int pairs_per_burst = 4;             // 4 words -> 8 samples -> 1 data record
    localparam int burst_w         = pairs_per_burst * pair_w;

    //////////////////////////////
    // configuration fields
    //////////////////////////////

    localparam int fill_num_w   = 24;
    localparam int fill_type_w  = 2;
    localparam int bursts_w     = 23;               // data records per waveform
    localparam int adr_w        = 23;               // ddr3 burst address
    localparam int adr_pad_w    = 3;                // zero lsbs under the address
    localparam int wave_cnt_w   = 12;
    localparam int gap_w        = 22;               // idle cycles between waveforms
    localparam int chan_tag_w   = 12;
    localparam int alarm_w      = 4;                // xadc alarm bits
    localparam int wave_spare_w = 16;               // unused top of the waveform header

endpackage

`default_nettype wire

//--- logic/acq_record_mux.sv
`default_nettype none

module acq_record_mux (
    input  logic                             clk,
    input  logic                             rst_n,
    // fill configuration, stable during a fill
    input  logic [acq_pkg::fill_num_w-1:0]   fill_num,
    input  logic [acq_pkg::fill_type_w-1:0]  fill_type,
    input  logic [acq_pkg::bursts_w-1:0]     num_fill_bursts,
    input  logic [acq_pkg::adr_w-1:0]        burst_start_adr,
    input  logic [acq_pkg::wave_cnt_w-1:0]   num_waveforms,
    input  logic [acq_pkg::gap_w-1:0]        waveform_gap,
    input  logic [acq_pkg::chan_tag_w-1:0]   channel_tag,
    input  logic [acq_pkg::alarm_w-1:0]      xadc_alarms,
    // from the sequencer and gatherer
    input  logic [acq_pkg::wave_cnt_w-1:0]   cur_wave_num,
    input  logic [acq_pkg::burst_w-1:0]      burst_dat,
    input  logic                             select_fill_hdr,
    input  logic                             select_wave_hdr,
    input  logic                             select_dat,   // also folds data into checksum
    input  logic                             select_checksum,
    // to the write fifo
    output logic [acq_pkg::rec_w-1:0]        rec_dat,
    output logic                             rec_valid
);
    import acq_pkg::*;

    logic [rec_w-1:0]   fill_hdr_rec;
    logic [rec_w-1:0]   wave_hdr_rec;
    logic [body_w-1:0]  dat_body;
    logic [body_w-1:0]  checksum;                       // running xor, tag excluded

    //////////////////////////////
    // fill header
    //////////////////////////////

    // msb first, see field order in the pkg widths
    assign fill_hdr_rec = {
        tag_fill_hdr,
        hdr_marker,
        xadc_alarms,
        channel_tag,
        waveform_gap,
        num_waveforms,
        burst_start_adr, {adr_pad_w{1'b0}},             // byte address, 3 lsbs zero
        num_fill_bursts,
        1'b0,                                           // reserved, wider fill type later
        fill_type,
        fill_num                                        // bits 23:0
    };

    //////////////////////////////
    // waveform header
    //////////////////////////////

    assign wave_hdr_rec = {
        tag_wave_hdr,
        hdr_marker,
        {wave_spare_w{1'b0}},                           // spare
        channel_tag,
        waveform_gap,
        cur_wave_num,                                   // 0 for the first waveform
        num_waveforms,
        burst_start_adr, {adr_pad_w{1'b0}},
        1'b0,                                           // reserved
        fill_type,
        num_fill_bursts                                 // bits 22:0
    };

    //////////////////////////////
    // data record
    //////////////////////////////

    // word k -> lanes 2k (low sample) and 2k+1 (high sample)
    // over-range lsb dropped, 12-bit sample sign extended to 16
    for (genvar k = 0; k < pairs_per_burst; k++) begin : g_lane
        logic [pair_w-1:0] pair;

        assign pair = burst_dat[k*pair_w +: pair_w];

        assign dat_body[2*k*lane_w +: lane_w] =
            {{(lane_w-smp_w){pair[smp_w]}}, pair[smp_w:1]};             // bits 12:1
        assign dat_body[(2*k+1)*lane_w +: lane_w] =
            {{(lane_w-smp_w){pair[pair_w-1]}}, pair[pair_w-1 -: smp_w]}; // bits 25:14
    end

    //////////////////////////////
    // checksum
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (select_fill_hdr) begin
            checksum <= fill_hdr_rec[body_w-1:0];                   // seed for a new fill
        end else if (select_wave_hdr) begin
            checksum <= checksum ^ wave_hdr_rec[body_w-1:0];
        end else if (select_dat) begin
            checksum <= checksum ^ dat_body;
        end
    end

    //////////////////////////////
    // output register
    //////////////////////////////

    // selects are one-hot from the sequencer, order here is arbitrary
    always_ff @(posedge clk) begin
        if (select_fill_hdr) begin
            rec_dat <= fill_hdr_rec;
        end else if (select_wave_hdr) begin
            rec_dat <= wave_hdr_rec;
        end else if (select_dat) begin
            rec_dat <= {tag_data, dat_body};
        end else if (select_checksum) begin
            rec_dat <= {tag_checksum, checksum};    // includes the last data word
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= select_fill_hdr || select_wave_hdr || select_dat || select_checksum;
        end
    end

endmodule

`default_nettype wire

//--- logic/acq_sequencer.sv
`default_nettype none

module acq_sequencer (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             trigger,          // starts a fill when not busy
    input  logic [acq_pkg::bursts_w-1:0]     num_fill_bursts,
    input  logic [acq_pkg::wave_cnt_w-1:0]   num_waveforms,    // 0 behaves as 1
    input  logic [acq_pkg::gap_w-1:0]        waveform_gap,
    input  logic                             burst_valid,
    output logic                             capture_en,
    output logic                             select_fill_hdr,
    output logic                             select_wave_hdr,
    output logic                             select_dat,
    output logic                             select_checksum,
    output logic [acq_pkg::wave_cnt_w-1:0]   cur_wave_num,
    output logic                             fill_busy,
    output logic                             fill_done
);
    import acq_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_fill_hdr,
        st_wave_hdr,
        st_data,
        st_gap,                 // select_dat cycle, then the quiet gap
        st_checksum
    } state_t;

    state_t                 state;
    state_t                 state_nxt;
    logic [bursts_w-1:0]    burst_cnt;              // data records sent in this waveform
    logic [bursts_w:0]      burst_cnt_inc;
    logic [wave_cnt_w:0]    wave_inc;
    logic [gap_w:0]         gap_cnt;                // extra bit, loads waveform_gap + 1
    logic                   last_burst;
    logic                   last_wave;
    logic                   gap_expired;

    // compare after increment so a zero count acts as one
    assign burst_cnt_inc = {1'b0, burst_cnt} + 1'b1;
    assign wave_inc      = {1'b0, cur_wave_num} + 1'b1;
    assign last_burst    = burst_cnt_inc >= {1'b0, num_fill_bursts};
    assign last_wave     = wave_inc >= {1'b0, num_waveforms};
    assign gap_expired   = gap_cnt == '0;

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle, st_checksum: begin
                state_nxt = trigger ? st_fill_hdr : st_idle;    // not busy in either
            end
            st_fill_hdr: state_nxt = st_wave_hdr;
            st_wave_hdr: state_nxt = st_data;
            st_data: begin
                if (burst_valid && last_burst) begin
                    state_nxt = st_gap;
                end
            end
            st_gap: begin
                if (gap_expired) begin
                    state_nxt = last_wave ? st_checksum : st_wave_hdr;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    //////////////////////////////
    // counters
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            burst_cnt <= '0;
        end else if (state == st_wave_hdr) begin
            burst_cnt <= '0;                                    // new waveform
        end else if (state == st_data && burst_valid) begin
            burst_cnt <= burst_cnt_inc[bursts_w-1:0];
        end
    end

    // gap state spans the select_dat cycle plus waveform_gap + 1 quiet cycles,
    // or only the select_dat cycle when the checksum comes next
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gap_cnt <= '0;
        end else if (state == st_data && burst_valid && last_burst) begin
            gap_cnt <= last_wave ? '0 : {1'b0, waveform_gap} + 1'b1;
        end else if (state == st_gap && !gap_expired) begin
            gap_cnt <= gap_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_wave_num <= '0;
        end else if (state == st_fill_hdr) begin
            cur_wave_num <= '0;
        end else if (state == st_gap && gap_expired && !last_wave) begin
            cur_wave_num <= wave_inc[wave_cnt_w-1:0];           // next waveform header
        end
    end

    //////////////////////////////
    // outputs
    //////////////////////////////

    // data record one cycle after each burst, lands in st_data or st_gap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            select_dat <= 1'b0;
        end else begin
            select_dat <= state == st_data && burst_valid;
        end
    end

    assign select_fill_hdr = state == st_fill_hdr;
    assign select_wave_hdr = state == st_wave_hdr;
    assign select_checksum = state == st_checksum;
    assign capture_en      = state == st_wave_hdr || state == st_data;  // gatherer runs
    assign fill_done       = state == st_checksum;                      // with the checksum
    assign fill_busy       = !(state == st_idle || state == st_checksum);

endmodule

`default_nettype wire

//--- logic/sample_gatherer.sv
`default_nettype none

module sample_gatherer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         capture_en,   // sequencer wants data
    input  logic [acq_pkg::pair_w-1:0]   adc_pair,
    input  logic                         adc_valid,
    output logic [acq_pkg::burst_w-1:0]  burst_dat,    // oldest word in slot 0
    output logic                         burst_valid
);
    import acq_pkg::*;

    logic                 accept;
    logic [1:0]           slot;                         // next slot to fill
    logic [pair_w-1:0]    hold [pairs_per_burst-1];     // words 0..2, the 4th goes direct

    assign accept = capture_en && adc_valid;

    //////////////////////////////
    // slot counter
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (!capture_en) begin
            slot <= '0;                                 // drop any partial burst
        end else if (accept) begin
            slot <= slot + 2'd1;                        // wraps after the 4th word
        end
    end

    // holding slots, payload only
    always_ff @(posedge clk) begin
        if (accept && slot != 2'd3) begin
            hold[slot] <= adc_pair;
        end
    end

    //////////////////////////////
    // burst hand-off
    //////////////////////////////

    // complete burst moves out on the 4th word
    // so the holding slots are free for the next one
    always_ff @(posedge clk) begin
        if (accept && slot == 2'd3) begin
            burst_dat <= {adc_pair, hold[2], hold[1], hold[0]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            burst_valid <= 1'b0;
        end else begin
            burst_valid <= accept && slot == 2'd3;      // one cycle after the 4th word
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f filelist.f --top-module acq_formatter_tb \
    -Mdir obj_dir -o sim_exe > sim.log 2>&1 &&
./obj_dir/sim_exe >> sim.log 2>&1 ||
echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && { echo "simulation FAILED"; exit 1; }
echo "simulation passed"
exit 0

//--- verification/acq_formatter_sva.sv
`default_nettype none

module acq_formatter_sva (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  select_fill_hdr,
    input  logic  select_wave_hdr,
    input  logic  select_dat,
    input  logic  select_checksum,
    input  logic  rec_valid,
    input  logic  fill_busy,
    input  logic  fill_done,
    input  logic  capture_en
);
    timeunit 1ns;
    timeprecision 1ps;

    logic any_sel;

    assign any_sel = select_fill_hdr || select_wave_hdr || select_dat || select_checksum;

    //////////////////////////////
    // record selects
    //////////////////////////////

    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({select_fill_hdr, select_wave_hdr, select_dat, select_checksum}))
        else $error("more than one record select high");

    a_rec_after_sel: assert property (@(posedge clk) disable iff (!rst_n)
        any_sel |=> rec_valid) else $error("select without rec_valid one cycle later");

    a_rec_only_after_sel: assert property (@(posedge clk) disable iff (!rst_n)
        rec_valid |-> $past(any_sel)) else $error("rec_valid without a select");

    //////////////////////////////
    // fill control
    //////////////////////////////

    a_done_ends_busy: assert property (@(posedge clk) disable iff (!rst_n)
        fill_done |-> !fill_busy && $past(fill_busy)) else $error("fill_done outside busy end");

    a_busy_ends_with_done: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(fill_busy) |-> fill_done) else $error("fill_busy fell without fill_done");

    a_idle_no_capture: assert property (@(posedge clk) disable iff (!rst_n)
        !fill_busy && !fill_done |-> !capture_en) else $error("capture_en high while idle");

endmodule

// selects and fill control from the sequencer, rec_valid from the mux
bind acq_formatter_top acq_formatter_sva u_sva (
    .clk(clk), .rst_n(rst_n),
    .select_fill_hdr(select_fill_hdr), .select_wave_hdr(select_wave_hdr),
    .select_dat(select_dat), .select_checksum(select_checksum), .rec_valid(rec_valid),
    .fill_busy(fill_busy), .fill_done(fill_done), .capture_en(capture_en)
);

`default_nettype wire

//--- verification/acq_formatter_tb.sv
`default_nettype none

module acq_formatter_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import acq_pkg::*;

    // one fill per row, exp_recs is the record count of the whole fill
    typedef struct packed {
        logic [fill_num_w-1:0]   fill_num;
        logic [fill_type_w-1:0]  fill_type;
        logic [bursts_w-1:0]     bursts;
        logic [adr_w-1:0]        adr;
        logic [wave_cnt_w-1:0]   waves;
        logic [gap_w-1:0]        gap;
        logic [chan_tag_w-1:0]   chan;
        logic [alarm_w-1:0]      alarms;
        logic [15:0]             exp_recs;
    } fill_row_t;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   trigger;
    logic [pair_w-1:0]      adc_pair;
    logic                   adc_valid;
    logic [fill_num_w-1:0]  fill_num;
    logic [fill_type_w-1:0] fill_type;
    logic [bursts_w-1:0]    num_fill_bursts;
    logic [adr_w-1:0]       burst_start_adr;
    logic [wave_cnt_w-1:0]  num_waveforms;
    logic [gap_w-1:0]       waveform_gap;
    logic [chan_tag_w-1:0]  channel_tag;
    logic [alarm_w-1:0]     xadc_alarms;
    logic [rec_w-1:0]       rec_dat;
    logic                   rec_valid;
    logic                   fill_busy;
    logic                   fill_done;

    fill_row_t              rows [6];
    fill_row_t              cur;                // fill in progress
    logic [pair_w-1:0]      pending [$];        // words of a partial burst
    logic [burst_w-1:0]     bursts_q [$];       // complete bursts, oldest first
    logic [tag_w-1:0]       exp_tags [$];
    logic [body_w-1:0]      exp_sum;            // model checksum
    logic                   busy_q = 1'b0;      // fill_busy one cycle back
    int                     wave_idx;
    int                     cyc = 0;
    int                     last_rec_cyc = 0;
    int                     done_cyc = 0;
    int                     done_cnt = 0;
    int                     rec_cnt = 0;
    int                     errors = 0;
    int                     checks = 0;
    int                     limit = 0;
    int                     seed = 32'h4cac_eec3;
    int                     rnd_valid;
    int                     rnd_pair;

    acq_formatter_top dut (.*);

    always #50 clk = ~clk;

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic logic [body_w-1:0] fill_hdr_body(input fill_row_t r);
        logic [body_w-1:0] b;
        b          = '0;
        b[23:0]    = r.fill_num;
        b[25:24]   = r.fill_type;           // bit 26 reserved
        b[49:27]   = r.bursts;
        b[75:53]   = r.adr;                 // 52:50 stay zero
        b[87:76]   = r.waves;
        b[109:88]  = r.gap;
        b[121:110] = r.chan;
        b[125:122] = r.alarms;
        b[127:126] = 2'b01;
        return b;
    endfunction

    function automatic logic [body_w-1:0] wave_hdr_body(input fill_row_t r, input int n);
        logic [body_w-1:0] b;
        b          = '0;
        b[22:0]    = r.bursts;
        b[24:23]   = r.fill_type;
        b[51:29]   = r.adr;                 // 28:26 zero pad, 25 reserved
        b[63:52]   = r.waves;
        b[75:64]   = n[11:0];
        b[97:76]   = r.gap;
        b[109:98]  = r.chan;
        b[127:126] = 2'b01;                 // 125:110 spare
        return b;
    endfunction

    // lanes 2k and 2k+1 from word k, over-range lsb dropped
    function automatic logic [body_w-1:0] data_body(input logic [burst_w-1:0] bw);
        logic [body_w-1:0] b;
        logic [pair_w-1:0] w;
        for (int k = 0; k < pairs_per_burst; k++) begin
            w                 = bw[k*pair_w +: pair_w];
            b[32*k +: 16]     = {{4{w[12]}}, w[12:1]};
            b[32*k+16 +: 16]  = {{4{w[25]}}, w[25:14]};
        end
        return b;
    endfunction

    task automatic check_record();
        logic [tag_w-1:0]  tag;
        logic [tag_w-1:0]  want_tag;
        logic [body_w-1:0] want;
        int                idle;
        tag     = rec_dat[rec_w-1 -: tag_w];
        checks  = checks + 1;
        rec_cnt = rec_cnt + 1;
        if (exp_tags.size() == 0) begin
            errors++;
            $display("FAILED at %0t: unexpected record with tag %0d", $time, tag);
            return;
        end
        want_tag = exp_tags.pop_front();
        if (tag != want_tag) begin
            errors++;
            $display("FAILED at %0t: tag %0d, expected %0d", $time, tag, want_tag);
        end
        case (want_tag)
            tag_fill_hdr: begin
                want     = fill_hdr_body(cur);
                exp_sum  = want;
                wave_idx = 0;
            end
            tag_wave_hdr: begin
                want    = wave_hdr_body(cur, wave_idx);
                exp_sum = exp_sum ^ want;
                idle    = cyc - last_rec_cyc - 1;
                if (wave_idx > 0 && idle != int'(cur.gap) + 1) begin
                    errors++;
                    $display("FAILED at %0t: gap of %0d idle cycles, expected %0d",
                             $time, idle, int'(cur.gap) + 1);
                end
                wave_idx++;
            end
            tag_data: begin
                want = '0;
                if (bursts_q.size() == 0) begin
                    errors++;
                    $display("FAILED at %0t: data record before four words were taken", $time);
                end else begin
                    want = data_body(bursts_q.pop_front());
                end
                exp_sum = exp_sum ^ want;
            end
            default: begin
                want = exp_sum;
                if (cyc != done_cyc + 1) begin
                    errors++;
                    $display("FAILED at %0t: checksum not one cycle after fill_done", $time);
                end
            end
        endcase
        if (rec_dat[body_w-1:0] !== want) begin
            errors++;
            $display("FAILED at %0t: tag %0d body %h, expected %h",
                     $time, want_tag, rec_dat[body_w-1:0], want);
        end
        last_rec_cyc = cyc;
    endtask

    // outputs and capture_en are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            cyc = cyc + 1;
            if (fill_done) begin
                done_cnt = done_cnt + 1;
                done_cyc = cyc;
            end
            if (fill_done && fill_busy) begin
                errors++;
                $display("FAILED at %0t: fill_busy still high with fill_done", $time);
            end
            if (busy_q && !fill_busy && !fill_done) begin
                errors++;
                $display("FAILED at %0t: fill_busy fell without fill_done", $time);
            end
            busy_q = fill_busy;
            if (rec_valid) begin
                check_record();
            end
            if (!dut.capture_en) begin
                pending.delete();               // partial burst is lost
            end else if (adc_valid) begin
                pending.push_back(adc_pair);    // taken on the next rising edge
                if (pending.size() == pairs_per_burst) begin
                    bursts_q.push_back({pending[3], pending[2], pending[1], pending[0]});
                    pending.delete();
                end
            end
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    always @(posedge clk) begin
        if (rst_n) begin
            rnd_valid = $random(seed);
            rnd_pair  = $random(seed);
            adc_valid <= rnd_valid[7:0] < 8'd154;   // about 60 percent
            adc_pair  <= rnd_pair[pair_w-1:0];
        end
    end

    always @(posedge clk) begin
        if (limit > 0 && cyc >= limit) begin
            $display("ERROR: timeout after %0d cycles, a fill did not finish", cyc);
            $display("Test failed");
            $finish;
        end
    end

    function automatic int timeout_limit();
        int sum;
        sum = 0;
        for (int i = 0; i < $size(rows); i++) begin
            sum += int'(rows[i].waves) * (int'(rows[i].bursts) * 8 + int'(rows[i].gap) + 4) + 50;
        end
        return sum;
    endfunction

    task automatic run_fill(input int i);
        int n_done;
        n_done  = done_cnt;
        rec_cnt = 0;
        @(posedge clk);
        fill_num        <= rows[i].fill_num;    // config settles before the trigger
        fill_type       <= rows[i].fill_type;
        num_fill_bursts <= rows[i].bursts;
        burst_start_adr <= rows[i].adr;
        num_waveforms   <= rows[i].waves;
        waveform_gap    <= rows[i].gap;
        channel_tag     <= rows[i].chan;
        xadc_alarms     <= rows[i].alarms;
        @(posedge clk);
        cur = rows[i];
        exp_tags.push_back(tag_fill_hdr);
        for (int w = 0; w < int'(rows[i].waves); w++) begin
            exp_tags.push_back(tag_wave_hdr);
            for (int b = 0; b < int'(rows[i].bursts); b++) begin
                exp_tags.push_back(tag_data);
            end
        end
        exp_tags.push_back(tag_checksum);
        trigger <= 1'b1;
        @(posedge clk);
        trigger <= 1'b0;
        // busy the cycle after the trigger
        @(negedge clk);
        if (!fill_busy) begin
            errors++;
            $display("FAILED at %0t: fill_busy not high the cycle after trigger", $time);
        end
        // second trigger lands inside the fill
        @(posedge clk);
        trigger <= 1'b1;
        @(posedge clk);
        trigger <= 1'b0;
        while (done_cnt == n_done) @(posedge clk);
        repeat (4) @(posedge clk);
        if (rec_cnt != int'(rows[i].exp_recs) || exp_tags.size() != 0) begin
            errors++;
            $display("FAILED at %0t: fill %0d gave %0d records, expected %0d",
                     $time, i, rec_cnt, rows[i].exp_recs);
        end
        if (done_cnt != n_done + 1) begin
            errors++;
            $display("FAILED at %0t: fill %0d saw %0d fill_done pulses", $time, i,
                     done_cnt - n_done);
        end
    endtask

    initial begin
        rst_n           = 1'b0;
        trigger         = 1'b0;
        adc_pair        = '0;
        adc_valid       = 1'b0;
        fill_num        = '0;
        fill_type       = '0;
        num_fill_bursts = '0;
        burst_start_adr = '0;
        num_waveforms   = '0;
        waveform_gap    = '0;
        channel_tag     = '0;
        xadc_alarms     = '0;
        // fill_num, type, bursts, adr, waveforms, gap, channel, alarms, records
        rows[0] = '{24'h000001, 2'd0, 23'd1, 23'h000100, 12'd1, 22'd0, 12'h0a1, 4'h0, 16'd4};
        rows[1] = '{24'h00a5c3, 2'd1, 23'd2, 23'h05a5a5, 12'd2, 22'd2, 12'hfff, 4'h5, 16'd8};
        rows[2] = '{24'hffffff, 2'd3, 23'd3, 23'h7fffff, 12'd3, 22'd5, 12'h123, 4'hf, 16'd14};
        rows[3] = '{24'h123456, 2'd2, 23'd1, 23'h000000, 12'd3, 22'd1, 12'h800, 4'h8, 16'd8};
        rows[4] = '{24'h800000, 2'd0, 23'd3, 23'h2aaaaa, 12'd2, 22'd0, 12'h055, 4'ha, 16'd10};
        rows[5] = '{24'h00ff00, 2'd1, 23'd2, 23'h400001, 12'd1, 22'd4, 12'h7ff, 4'h3, 16'd5};
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        limit = timeout_limit();
        for (int i = 0; i < $size(rows); i++) begin
            run_fill(i);
        end
        $display("%0d fills, %0d records checked, %0d errors", $size(rows), checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
